// ==== rv_hazard_pkg.sv ====
`default_nettype none

package rv_hazard_pkg;

  // Hazard unit configuration
  // Forwarding to EX is assumed to exist outside this model
  localparam int FWD = 1;
  // The register file has no write-through, so a WB producer must stall ID
  localparam int FWD_REGFILE = 0;

  localparam int MEM_TYPE_BRAM = 0;
  localparam int MEM_TYPE_SRAM = 1;
  localparam int MEM_TYPE = MEM_TYPE_BRAM;

  // Redirect takes effect one cycle late when the PC is registered
  localparam int PC_REG = 1;

  // A multiply stays in EX for this many cycles
  localparam int MUL_CYCLES = 3;

  // Stage registers after ID and their indices in the stage vectors
  localparam int NUM_STAGES = 3;
  localparam int STAGE_EX = 0;
  localparam int STAGE_MEM = 1;
  localparam int STAGE_WB = 2;

  localparam int REG_W = 5;
  localparam int TAG_W = 8;
  localparam int KIND_W = 2;

  // Result kind of a descriptor, which decides when its value can be forwarded
  localparam logic [KIND_W-1:0] KIND_ALU = 2'd0;
  localparam logic [KIND_W-1:0] KIND_LOAD = 2'd1;
  localparam logic [KIND_W-1:0] KIND_CSR = 2'd2;
  localparam logic [KIND_W-1:0] KIND_MUL = 2'd3;

  localparam int PC_SEL_W = 2;
  localparam logic [PC_SEL_W-1:0] PC_SEL_SEQ = 2'd0;
  localparam logic [PC_SEL_W-1:0] PC_SEL_PREDICTED = 2'd1;
  localparam logic [PC_SEL_W-1:0] PC_SEL_REDIRECT = 2'd2;

  // Packed descriptor layout, LSB first
  // The mispredict flag sits at bit 0, then kind, reg_write, rd and the tag on top
  localparam int MISP_BIT = 0;
  localparam int KIND_LSB = MISP_BIT + 1;
  localparam int WE_BIT = KIND_LSB + KIND_W;
  localparam int RD_LSB = WE_BIT + 1;
  localparam int TAG_LSB = RD_LSB + REG_W;
  localparam int DESC_W = TAG_LSB + TAG_W;

endpackage

`default_nettype wire

// ==== rv_hazard.sv ====
`timescale 1ns/1ns
`default_nettype none

// Hazard detection for the ID issue slot
// Everything here is combinational, so the stall and flushes follow their inputs
// in the same cycle
module rv_hazard #(
  parameter int FWD = rv_hazard_pkg::FWD,
  parameter int FWD_REGFILE = rv_hazard_pkg::FWD_REGFILE,
  parameter int MEM_TYPE = rv_hazard_pkg::MEM_TYPE,
  parameter int PC_REG = rv_hazard_pkg::PC_REG
) (
  input  logic [rv_hazard_pkg::REG_W-1:0]    rs1_id,
  input  logic [rv_hazard_pkg::REG_W-1:0]    rs2_id,
  input  logic                               rs1_used_id,
  input  logic                               rs2_used_id,
  input  logic                               valid_ex,
  input  logic [rv_hazard_pkg::REG_W-1:0]    rd_ex,
  input  logic                               reg_write_ex,
  input  logic [rv_hazard_pkg::KIND_W-1:0]   kind_ex,
  input  logic                               op_active_ex,
  input  logic                               valid_mem,
  input  logic [rv_hazard_pkg::REG_W-1:0]    rd_mem,
  input  logic                               reg_write_mem,
  input  logic [rv_hazard_pkg::KIND_W-1:0]   kind_mem,
  input  logic                               mispredict_mem,
  input  logic                               valid_wb,
  input  logic [rv_hazard_pkg::REG_W-1:0]    rd_wb,
  input  logic                               reg_write_wb,
  input  logic [rv_hazard_pkg::PC_SEL_W-1:0] pc_sel,
  input  logic                               btb_pred_taken,
  input  logic                               ras_pred_taken,
  input  logic                               redir_pending_if,
  input  logic                               stall_ex,
  input  logic                               stall_mem,
  output logic                               data_hazard_id,
  output logic                               if_id_flush,
  output logic                               id_ex_flush,
  output logic                               ex_mem_flush
);

  // True when a valid producer writes a register that ID actually reads
  // Register zero never creates a dependency
  function automatic logic src_match(
    input logic                            valid,
    input logic                            we,
    input logic [rv_hazard_pkg::REG_W-1:0] rd,
    input logic [rv_hazard_pkg::REG_W-1:0] rs1,
    input logic                            rs1_used,
    input logic [rv_hazard_pkg::REG_W-1:0] rs2,
    input logic                            rs2_used
  );
    src_match = valid && we && (rd != '0) &&
                ((rs1_used && (rd == rs1)) || (rs2_used && (rd == rs2)));
  endfunction

  logic ex_hit;
  logic mem_hit;
  logic wb_hit;
  logic wb_stall;
  logic sram;
  logic late_ex;
  logic late_mem;
  logic raw_stall;
  logic redir_mem;
  logic control_flush;
  logic pred_flush;
  logic pend_redir;

  assign ex_hit = src_match(valid_ex, reg_write_ex, rd_ex,
                            rs1_id, rs1_used_id, rs2_id, rs2_used_id);
  assign mem_hit = src_match(valid_mem, reg_write_mem, rd_mem,
                             rs1_id, rs1_used_id, rs2_id, rs2_used_id);
  assign wb_hit = src_match(valid_wb, reg_write_wb, rd_wb,
                            rs1_id, rs1_used_id, rs2_id, rs2_used_id);

  // Without write-through in the register file the WB value is not visible to ID yet
  assign wb_stall = (FWD_REGFILE == 0) && wb_hit;

  // Results that forwarding cannot deliver in time
  // CSR and multiply values only exist at WB
  // SRAM load data is ready in MEM, BRAM data only in WB
  assign sram = (MEM_TYPE == rv_hazard_pkg::MEM_TYPE_SRAM);
  assign late_ex = (kind_ex == rv_hazard_pkg::KIND_CSR) ||
                   (kind_ex == rv_hazard_pkg::KIND_MUL) ||
                   (!sram && (kind_ex == rv_hazard_pkg::KIND_LOAD));
  assign late_mem = (kind_mem == rv_hazard_pkg::KIND_CSR) ||
                    (kind_mem == rv_hazard_pkg::KIND_MUL) ||
                    (!sram && (kind_mem == rv_hazard_pkg::KIND_LOAD));

  // With forwarding only late producers stall ID; without it every match does
  assign raw_stall = (FWD != 0) ?
                     ((late_ex && ex_hit) || (late_mem && mem_hit) || wb_stall) :
                     (ex_hit || mem_hit || wb_stall);

  // A mispredicted branch resolved in MEM redirects the front end
  assign redir_mem = valid_mem && mispredict_mem;
  assign control_flush = (pc_sel == rv_hazard_pkg::PC_SEL_REDIRECT) || redir_mem;

  // The stalled consumer is on the wrong path during a redirect, so release it
  assign data_hazard_id = raw_stall && !control_flush;

  // BTB hits steer fetch early and need no flush
  // A RAS or static prediction comes after the sequential fetch, which must go
  // It only fires when ID really advances
  assign pred_flush = (pc_sel == rv_hazard_pkg::PC_SEL_PREDICTED) &&
                      (!btb_pred_taken || ras_pred_taken) &&
                      !data_hazard_id && !op_active_ex && !stall_ex;

  // With a registered PC one more wrong-path fetch slips in after the redirect
  assign pend_redir = (PC_REG != 0) && redir_pending_if;

  assign if_id_flush = control_flush || pred_flush || pend_redir;

  // A stalled EX still holds the redirecting instruction and must keep it
  assign id_ex_flush = (control_flush && !stall_ex) || pend_redir;

  // MEM gets bubbles behind a redirect, and while a multiply is busy in EX
  assign ex_mem_flush = (redir_mem && !stall_mem) || op_active_ex;

endmodule

`default_nettype wire

// ==== rv_id_issue.sv ====
`timescale 1ns/1ns
`default_nettype none

// ID issue slot holding one decoded descriptor
module rv_id_issue (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               in_valid,
  input  logic [rv_hazard_pkg::TAG_W-1:0]    in_tag,
  input  logic [rv_hazard_pkg::REG_W-1:0]    in_rs1,
  input  logic [rv_hazard_pkg::REG_W-1:0]    in_rs2,
  input  logic                               in_rs1_used,
  input  logic                               in_rs2_used,
  input  logic [rv_hazard_pkg::REG_W-1:0]    in_rd,
  input  logic                               in_reg_write,
  input  logic [rv_hazard_pkg::KIND_W-1:0]   in_kind,
  input  logic                               in_mispredict,
  input  logic                               data_hazard_id,
  input  logic                               ex_hold,
  input  logic                               if_id_flush,
  output logic                               in_ready,
  output logic [rv_hazard_pkg::REG_W-1:0]    rs1_id,
  output logic [rv_hazard_pkg::REG_W-1:0]    rs2_id,
  output logic                               rs1_used_id,
  output logic                               rs2_used_id,
  output logic                               issue_valid,
  output logic [rv_hazard_pkg::DESC_W-1:0]   issue_desc,
  output logic                               id_hold
);

  logic                             slot_valid;
  logic                             take;
  logic [rv_hazard_pkg::REG_W-1:0]  rs1_q;
  logic [rv_hazard_pkg::REG_W-1:0]  rs2_q;
  logic                             rs1_used_q;
  logic                             rs2_used_q;
  logic [rv_hazard_pkg::DESC_W-1:0] desc_q;

  // ID waits on a data hazard or on anything that keeps EX occupied
  assign id_hold = data_hazard_id || ex_hold;
  assign issue_valid = slot_valid && !id_hold;

  // The slot frees up in the same cycle its descriptor issues
  assign in_ready = !slot_valid || !id_hold;
  assign take = in_valid && in_ready;

  // A new descriptor wins over a flush on the same edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      slot_valid <= 1'b0;
    end else if (take) begin
      slot_valid <= 1'b1;
    end else if (if_id_flush || issue_valid) begin
      slot_valid <= 1'b0;
    end
  end

  // Sources stay beside the slot and only the stage fields travel on
  always_ff @(posedge clk) begin
    if (take) begin
      rs1_q <= in_rs1;
      rs2_q <= in_rs2;
      rs1_used_q <= in_rs1_used;
      rs2_used_q <= in_rs2_used;
      desc_q <= {in_tag, in_rd, in_reg_write, in_kind, in_mispredict};
    end
  end

  assign rs1_id = rs1_q;
  assign rs2_id = rs2_q;
  // An empty slot reads nothing and so raises no hazard
  assign rs1_used_id = slot_valid && rs1_used_q;
  assign rs2_used_id = slot_valid && rs2_used_q;
  assign issue_desc = desc_q;

endmodule

`default_nettype wire

// ==== rv_stage_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

// One pipeline register carrying a stage descriptor
module rv_stage_reg (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             in_valid,
  input  logic [rv_hazard_pkg::DESC_W-1:0] in_desc,
  input  logic                             in_hold,
  input  logic                             hold,
  input  logic                             flush,
  output logic                             valid,
  output logic [rv_hazard_pkg::DESC_W-1:0] desc
);

  logic                             valid_q;
  logic [rv_hazard_pkg::DESC_W-1:0] desc_q;

  // Hold keeps the stage as it is, even against a flush
  // Otherwise a flush, a held upstream or an empty upstream gives a bubble
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else if (!hold) begin
      valid_q <= in_valid && !in_hold && !flush;
    end
  end

  // The payload follows upstream whenever the stage moves
  // Under a bubble it is simply ignored
  always_ff @(posedge clk) begin
    if (!hold) begin
      desc_q <= in_desc;
    end
  end

  assign valid = valid_q;
  assign desc = desc_q;

endmodule

`default_nettype wire

// ==== rv_ex_occupancy.sv ====
`timescale 1ns/1ns
`default_nettype none

// Keeps a multiply in EX for a fixed number of cycles and builds the stage holds
module rv_ex_occupancy (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic                                 ex_valid,
  input  logic [rv_hazard_pkg::KIND_W-1:0]     ex_kind,
  input  logic                                 stall_ex,
  input  logic                                 stall_mem,
  input  logic                                 stall_wb,
  output logic                                 op_active_ex,
  output logic [rv_hazard_pkg::NUM_STAGES-1:0] stage_hold
);

  localparam int CNT_W = $clog2(rv_hazard_pkg::MUL_CYCLES + 1);

  logic [CNT_W-1:0] cnt;
  logic             seen;
  logic             fresh;

  // A multiply is fresh in its first cycle in EX, before it has been counted
  assign fresh = ex_valid && (ex_kind == rv_hazard_pkg::KIND_MUL) && !seen;
  assign op_active_ex = fresh || (cnt != '0);

  // Back-pressure runs from WB upwards, so each stage also waits on the ones below
  assign stage_hold[rv_hazard_pkg::STAGE_WB] = stall_wb;
  assign stage_hold[rv_hazard_pkg::STAGE_MEM] = stall_mem || stall_wb;
  assign stage_hold[rv_hazard_pkg::STAGE_EX] = op_active_ex || stall_ex ||
                                               stage_hold[rv_hazard_pkg::STAGE_MEM];

  // The fresh cycle counts as the first busy cycle, so load one less
  // seen stays up until EX moves on, which stops a finished multiply being counted again
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
      seen <= 1'b0;
    end else begin
      if (fresh) begin
        cnt <= CNT_W'(rv_hazard_pkg::MUL_CYCLES - 1);
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end
      seen <= fresh || (seen && stage_hold[rv_hazard_pkg::STAGE_EX]);
    end
  end

endmodule

`default_nettype wire

// ==== rv_hazard_top.sv ====
`timescale 1ns/1ns
`default_nettype none

// Hazard-control path of a five-stage pipeline with the ID slot, EX, MEM and WB
module rv_hazard_top (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               in_valid,
  input  logic [rv_hazard_pkg::TAG_W-1:0]    in_tag,
  input  logic [rv_hazard_pkg::REG_W-1:0]    in_rs1,
  input  logic [rv_hazard_pkg::REG_W-1:0]    in_rs2,
  input  logic                               in_rs1_used,
  input  logic                               in_rs2_used,
  input  logic [rv_hazard_pkg::REG_W-1:0]    in_rd,
  input  logic                               in_reg_write,
  input  logic [rv_hazard_pkg::KIND_W-1:0]   in_kind,
  input  logic                               in_mispredict,
  input  logic [rv_hazard_pkg::PC_SEL_W-1:0] pc_sel,
  input  logic                               btb_pred_taken,
  input  logic                               ras_pred_taken,
  input  logic                               redir_pending_if,
  input  logic                               stall_ex,
  input  logic                               stall_mem,
  input  logic                               stall_wb,
  output logic                               in_ready,
  output logic                               data_hazard_id,
  output logic                               if_id_flush,
  output logic                               id_ex_flush,
  output logic                               ex_mem_flush,
  output logic                               retire_valid,
  output logic [rv_hazard_pkg::TAG_W-1:0]    retire_tag
);

  localparam int NS = rv_hazard_pkg::NUM_STAGES;
  localparam int EX = rv_hazard_pkg::STAGE_EX;
  localparam int MEM = rv_hazard_pkg::STAGE_MEM;
  localparam int WB = rv_hazard_pkg::STAGE_WB;

  logic [rv_hazard_pkg::REG_W-1:0]  rs1_id;
  logic [rv_hazard_pkg::REG_W-1:0]  rs2_id;
  logic                             rs1_used_id;
  logic                             rs2_used_id;
  logic                             issue_valid;
  logic [rv_hazard_pkg::DESC_W-1:0] issue_desc;
  logic                             id_hold;
  logic                             op_active_ex;
  logic [NS-1:0]                    stage_hold;
  logic [NS-1:0]                    stage_flush;
  logic [NS-1:0]                    stage_valid;
  logic [rv_hazard_pkg::DESC_W-1:0] stage_desc [NS];

  rv_id_issue u_id_issue (
    .clk, .arst_n, .in_valid, .in_tag, .in_rs1, .in_rs2, .in_rs1_used, .in_rs2_used,
    .in_rd, .in_reg_write, .in_kind, .in_mispredict, .data_hazard_id,
    .ex_hold(stage_hold[EX]), .if_id_flush, .in_ready, .rs1_id, .rs2_id,
    .rs1_used_id, .rs2_used_id, .issue_valid, .issue_desc, .id_hold
  );

  // WB always retires, so it never sees a flush
  assign stage_flush[EX] = id_ex_flush;
  assign stage_flush[MEM] = ex_mem_flush;
  assign stage_flush[WB] = 1'b0;

  // EX is fed by the ID slot and every later stage by the one before it
  for (genvar i = 0; i < NS; i++) begin : g_stage
    logic                             up_valid;
    logic [rv_hazard_pkg::DESC_W-1:0] up_desc;
    logic                             up_hold;

    if (i == 0) begin : g_src
      assign up_valid = issue_valid;
      assign up_desc = issue_desc;
      assign up_hold = id_hold;
    end else begin : g_src
      assign up_valid = stage_valid[i-1];
      assign up_desc = stage_desc[i-1];
      assign up_hold = stage_hold[i-1];
    end

    rv_stage_reg u_stage (
      .clk, .arst_n, .in_valid(up_valid), .in_desc(up_desc), .in_hold(up_hold),
      .hold(stage_hold[i]), .flush(stage_flush[i]),
      .valid(stage_valid[i]), .desc(stage_desc[i])
    );
  end

  rv_ex_occupancy u_ex_occupancy (
    .clk, .arst_n, .ex_valid(stage_valid[EX]),
    .ex_kind(stage_desc[EX][rv_hazard_pkg::KIND_LSB +: rv_hazard_pkg::KIND_W]),
    .stall_ex, .stall_mem, .stall_wb, .op_active_ex, .stage_hold
  );

  rv_hazard u_hazard (
    .rs1_id, .rs2_id, .rs1_used_id, .rs2_used_id,
    .valid_ex(stage_valid[EX]),
    .rd_ex(stage_desc[EX][rv_hazard_pkg::RD_LSB +: rv_hazard_pkg::REG_W]),
    .reg_write_ex(stage_desc[EX][rv_hazard_pkg::WE_BIT]),
    .kind_ex(stage_desc[EX][rv_hazard_pkg::KIND_LSB +: rv_hazard_pkg::KIND_W]),
    .op_active_ex,
    .valid_mem(stage_valid[MEM]),
    .rd_mem(stage_desc[MEM][rv_hazard_pkg::RD_LSB +: rv_hazard_pkg::REG_W]),
    .reg_write_mem(stage_desc[MEM][rv_hazard_pkg::WE_BIT]),
    .kind_mem(stage_desc[MEM][rv_hazard_pkg::KIND_LSB +: rv_hazard_pkg::KIND_W]),
    .mispredict_mem(stage_desc[MEM][rv_hazard_pkg::MISP_BIT]),
    .valid_wb(stage_valid[WB]),
    .rd_wb(stage_desc[WB][rv_hazard_pkg::RD_LSB +: rv_hazard_pkg::REG_W]),
    .reg_write_wb(stage_desc[WB][rv_hazard_pkg::WE_BIT]),
    .pc_sel, .btb_pred_taken, .ras_pred_taken, .redir_pending_if, .stall_ex, .stall_mem,
    .data_hazard_id, .if_id_flush, .id_ex_flush, .ex_mem_flush
  );

  // Retirement is whatever sits valid in WB this cycle
  assign retire_valid = stage_valid[WB];
  assign retire_tag = stage_desc[WB][rv_hazard_pkg::TAG_LSB +: rv_hazard_pkg::TAG_W];

endmodule

`default_nettype wire

// ==== rv_hazard_tb_clk.sv ====
`timescale 1ns/1ns
`default_nettype none

// Free-running testbench clock and an active-low reset held for a few cycles
module rv_hazard_tb_clk #(
  parameter int PERIOD = 40,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset goes away between edges so no flop sees it change on a clock edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #(PERIOD / 4);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== rv_hazard_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

// Random testbench for the hazard-control path, checked against a cycle model
module rv_hazard_tb;

  localparam int NUM_CYCLES = 2000;
  localparam int CYCLE_LIMIT = NUM_CYCLES + 200;
  localparam int DRIVE_DELAY = 2;
  localparam int NS = rv_hazard_pkg::NUM_STAGES;
  localparam int EX = rv_hazard_pkg::STAGE_EX;
  localparam int MEM = rv_hazard_pkg::STAGE_MEM;
  localparam int WB = rv_hazard_pkg::STAGE_WB;
  localparam int REG_W = rv_hazard_pkg::REG_W;
  localparam int KIND_W = rv_hazard_pkg::KIND_W;

  logic clk, arst_n, in_valid, in_rs1_used, in_rs2_used, in_reg_write, in_mispredict;
  logic [rv_hazard_pkg::TAG_W-1:0] in_tag;
  logic [rv_hazard_pkg::REG_W-1:0] in_rs1, in_rs2, in_rd;
  logic [rv_hazard_pkg::KIND_W-1:0] in_kind;
  logic [rv_hazard_pkg::PC_SEL_W-1:0] pc_sel;
  logic btb_pred_taken, ras_pred_taken, redir_pending_if, stall_ex, stall_mem, stall_wb;
  logic in_ready, data_hazard_id, if_id_flush, id_ex_flush, ex_mem_flush, retire_valid;
  logic [rv_hazard_pkg::TAG_W-1:0] retire_tag;

  // Model state of the ID slot, the three stages and the multiply counter
  logic s_valid, s_u1, s_u2, s_we, s_misp;
  logic [rv_hazard_pkg::TAG_W-1:0] s_tag, next_tag, last_tag, tag_step;
  logic [rv_hazard_pkg::REG_W-1:0] s_rs1, s_rs2, s_rd;
  logic [rv_hazard_pkg::KIND_W-1:0] s_kind;
  logic m_valid [NS];
  logic m_we [NS];
  logic m_misp [NS];
  logic [rv_hazard_pkg::TAG_W-1:0] m_tag [NS];
  logic [rv_hazard_pkg::REG_W-1:0] m_rd [NS];
  logic [rv_hazard_pkg::KIND_W-1:0] m_kind [NS];
  logic m_ex_new;
  int m_cnt;
  // Expected combinational values for the current cycle
  logic e_fresh, e_op, e_hz, e_ctrl, e_ifid, e_idex, e_exmem, e_idhold, e_issue;
  logic e_ready, e_take;
  logic e_hold [NS];
  logic [31:0] rng_state = 32'h242f;
  logic seen_retire;
  int errors, checks, cycle_count, model_retires, dut_retires;

  rv_hazard_tb_clk #(.PERIOD(40), .RESET_CYCLES(8)) u_clk (.clk, .arst_n);

  rv_hazard_top u_dut (
    .clk, .arst_n, .in_valid, .in_tag, .in_rs1, .in_rs2, .in_rs1_used, .in_rs2_used,
    .in_rd, .in_reg_write, .in_kind, .in_mispredict, .pc_sel, .btb_pred_taken,
    .ras_pred_taken, .redir_pending_if, .stall_ex, .stall_mem, .stall_wb, .in_ready,
    .data_hazard_id, .if_id_flush, .id_ex_flush, .ex_mem_flush, .retire_valid, .retire_tag
  );

  // LCG step whose upper bits give the better spread
  function automatic int rand_below(input int n);
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return int'(rng_state[31:16]) % n;
  endfunction

  // A valid producer in a stage that writes a register the slot reads
  function automatic logic reads_reg(input logic valid, input logic we,
                                     input logic [rv_hazard_pkg::REG_W-1:0] rd);
    return valid && we && (rd != 0) && s_valid &&
           ((s_u1 && (rd == s_rs1)) || (s_u2 && (rd == s_rs2)));
  endfunction

  // Kinds whose result cannot be forwarded in time with BRAM memory
  function automatic logic late_kind(input logic [rv_hazard_pkg::KIND_W-1:0] kind);
    return (kind == rv_hazard_pkg::KIND_CSR) || (kind == rv_hazard_pkg::KIND_MUL) ||
           ((kind == rv_hazard_pkg::KIND_LOAD) &&
            (rv_hazard_pkg::MEM_TYPE == rv_hazard_pkg::MEM_TYPE_BRAM));
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("[FAIL] %s expected %0h actual %0h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic reset_model();
    s_valid = 1'b0;
    for (int i = 0; i < NS; i++) begin
      m_valid[i] = 1'b0;
    end
    m_ex_new = 1'b0;
    m_cnt = 0;
    next_tag = '0;
  endtask

  // Works out every expected output from the model state and the driven inputs
  task automatic eval_model();
    logic ex_hit, mem_hit, wb_hit, wb_stall, raw, redir, pred, pend;
    e_fresh = m_valid[EX] && (m_kind[EX] == rv_hazard_pkg::KIND_MUL) && m_ex_new;
    e_op = e_fresh || (m_cnt != 0);
    e_hold[WB] = stall_wb;
    e_hold[MEM] = stall_mem || stall_wb;
    e_hold[EX] = e_op || stall_ex || e_hold[MEM];
    ex_hit = reads_reg(m_valid[EX], m_we[EX], m_rd[EX]);
    mem_hit = reads_reg(m_valid[MEM], m_we[MEM], m_rd[MEM]);
    wb_hit = reads_reg(m_valid[WB], m_we[WB], m_rd[WB]);
    wb_stall = (rv_hazard_pkg::FWD_REGFILE == 0) && wb_hit;
    if (rv_hazard_pkg::FWD != 0) begin
      raw = (late_kind(m_kind[EX]) && ex_hit) || (late_kind(m_kind[MEM]) && mem_hit) ||
            wb_stall;
    end else begin
      raw = ex_hit || mem_hit || wb_stall;
    end
    redir = m_valid[MEM] && m_misp[MEM];
    e_ctrl = (pc_sel == rv_hazard_pkg::PC_SEL_REDIRECT) || redir;
    e_hz = raw && !e_ctrl;
    pred = (pc_sel == rv_hazard_pkg::PC_SEL_PREDICTED) && (!btb_pred_taken || ras_pred_taken)
           && !e_hz && !e_op && !stall_ex;
    pend = (rv_hazard_pkg::PC_REG != 0) && redir_pending_if;
    e_ifid = e_ctrl || pred || pend;
    e_idex = (e_ctrl && !stall_ex) || pend;
    e_exmem = (redir && !stall_mem) || e_op;
    e_idhold = e_hz || e_hold[EX];
    e_issue = s_valid && !e_idhold;
    e_ready = !s_valid || !e_idhold;
    e_take = in_valid && e_ready;
  endtask

  // The model's clock edge walks from WB back so each stage reads old upstream state
  task automatic advance_model();
    logic up_valid, up_hold, up_flush;
    for (int i = NS - 1; i >= 0; i--) begin
      if (!e_hold[i]) begin
        if (i == EX) begin
          up_valid = e_issue;
          up_hold = e_idhold;
          up_flush = e_idex;
          m_tag[i] = s_tag;
          m_rd[i] = s_rd;
          m_we[i] = s_we;
          m_kind[i] = s_kind;
          m_misp[i] = s_misp;
        end else begin
          up_valid = m_valid[i-1];
          up_hold = e_hold[i-1];
          up_flush = (i == MEM) ? e_exmem : 1'b0;
          m_tag[i] = m_tag[i-1];
          m_rd[i] = m_rd[i-1];
          m_we[i] = m_we[i-1];
          m_kind[i] = m_kind[i-1];
          m_misp[i] = m_misp[i-1];
        end
        m_valid[i] = up_valid && !up_hold && !up_flush;
      end
    end
    // A multiply counts as new only in the cycle right after it moved into EX
    m_ex_new = !e_hold[EX];
    if (e_fresh) begin
      m_cnt = rv_hazard_pkg::MUL_CYCLES - 1;
    end else if (m_cnt != 0) begin
      m_cnt--;
    end
    if (e_take) begin
      s_valid = 1'b1;
      s_tag = in_tag;
      s_rs1 = in_rs1;
      s_rs2 = in_rs2;
      s_u1 = in_rs1_used;
      s_u2 = in_rs2_used;
      s_rd = in_rd;
      s_we = in_reg_write;
      s_kind = in_kind;
      s_misp = in_mispredict;
      next_tag++;
    end else if (e_ifid || e_issue) begin
      s_valid = 1'b0;
    end
  endtask

  // Small register pool for frequent hazards, rare stalls and redirects
  task automatic drive_inputs();
    int r;
    in_valid = rand_below(10) < 7;
    in_tag = next_tag;
    in_rs1 = REG_W'(rand_below(4));
    in_rs2 = REG_W'(rand_below(4));
    in_rd = REG_W'(rand_below(4));
    in_rs1_used = rand_below(5) != 0;
    in_rs2_used = rand_below(5) != 0;
    in_reg_write = rand_below(5) != 0;
    in_kind = KIND_W'(rand_below(4));
    in_mispredict = rand_below(20) == 0;
    r = rand_below(100);
    if (r < 80) pc_sel = rv_hazard_pkg::PC_SEL_SEQ;
    else if (r < 92) pc_sel = rv_hazard_pkg::PC_SEL_PREDICTED;
    else if (r < 97) pc_sel = rv_hazard_pkg::PC_SEL_REDIRECT;
    else pc_sel = 2'd3;
    btb_pred_taken = rand_below(2) != 0;
    ras_pred_taken = rand_below(2) != 0;
    redir_pending_if = rand_below(33) == 0;
    stall_ex = rand_below(25) == 0;
    stall_mem = rand_below(25) == 0;
    stall_wb = rand_below(25) == 0;
  endtask

  task automatic check_reset_state();
    check_value("reset_retire_valid", 0, retire_valid);
    check_value("reset_if_id_flush", 0, if_id_flush);
    check_value("reset_id_ex_flush", 0, id_ex_flush);
    check_value("reset_ex_mem_flush", 0, ex_mem_flush);
    check_value("reset_data_hazard_id", 0, data_hazard_id);
    check_value("reset_in_ready", 1, in_ready);
  endtask

  task automatic compare_outputs();
    check_value("hazard_stall", e_hz, data_hazard_id);
    check_value("if_id_flush", e_ifid, if_id_flush);
    check_value("id_ex_flush", e_idex, id_ex_flush);
    check_value("ex_mem_flush", e_exmem, ex_mem_flush);
    check_value("in_ready", e_ready, in_ready);
    check_value("retire_valid", m_valid[WB], retire_valid);
    if (m_valid[WB]) check_value("retire_tag", m_tag[WB], retire_tag);
    if (e_ctrl) check_value("control_flush_hazard", 0, data_hazard_id);
    if (e_op) check_value("mul_mem_bubble", 1, ex_mem_flush);
    // A tag retires in the cycle it leaves WB, which a WB stall delays
    if (m_valid[WB] && !stall_wb) model_retires++;
    if (retire_valid && !stall_wb) begin
      dut_retires++;
      tag_step = retire_tag - last_tag;
      if (seen_retire) begin
        checks++;
        assert (tag_step != 0 && tag_step < 8'd128) else begin
          errors++;
          $display("[FAIL] retire_order expected a tag after %0h actual %0h",
                   last_tag, retire_tag);
        end
      end
      last_tag = retire_tag;
      seen_retire = 1'b1;
    end
  endtask

  // Hard limit on the run length in case the stimulus loop stops advancing
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    {in_valid, in_tag, in_rs1, in_rs2, in_rs1_used, in_rs2_used, in_rd} = '0;
    {in_reg_write, in_kind, in_mispredict, btb_pred_taken, ras_pred_taken} = '0;
    {redir_pending_if, stall_ex, stall_mem, stall_wb} = '0;
    pc_sel = rv_hazard_pkg::PC_SEL_SEQ;
    {errors, checks, cycle_count, model_retires, dut_retires} = '0;
    seen_retire = 1'b0;
    last_tag = '0;
    reset_model();
    // The last pass lands right after reset is released, before any edge
    @(negedge clk);
    check_reset_state();
    while (!arst_n) begin
      @(negedge clk);
      check_reset_state();
    end
    eval_model();
    for (int c = 0; c < NUM_CYCLES; c++) begin
      @(posedge clk);
      advance_model();
      #DRIVE_DELAY;
      drive_inputs();
      eval_model();
      @(negedge clk);
      compare_outputs();
    end
    check_value("retire_count", model_retires, dut_retires);
    $display("Run over: %0d checks, %0d errors, %0d retired", checks, errors, dut_retires);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv_hazard.f ====
rv_hazard_pkg.sv
rv_hazard.sv
rv_id_issue.sv
rv_stage_reg.sv
rv_ex_occupancy.sv
rv_hazard_top.sv
rv_hazard_tb_clk.sv
rv_hazard_tb.sv
